// File: hw/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR
    } alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] addr; // word address
        logic [XLEN-1:0] data;
    } imem_load_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
    } fetch_out_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  arith;
        logic                  use_imm; // second operand is the immediate
        logic                  load;
        logic                  store;
        logic                  branch;
        logic                  jal;
        logic                  illegal;
        alu_op_e               alu_op;
        logic                  branch_ne;
        logic [XLEN-1:0]       rs1_val;
        logic [XLEN-1:0]       rs2_val;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
    } decode_out_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  load;
        logic                  store;
        logic                  illegal;
        logic [XLEN-1:0]       result; // alu value, memory address or link value
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic                  redirect;
        logic [XLEN-1:0]       target;
    } execute_out_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic                  illegal;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic                  redirect;
        logic [XLEN-1:0]       target;
        logic [XLEN-1:0]       value;
    } mem_out_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       value;
        logic                  we;
        logic                  illegal;
    } retire_t;

endpackage

// File: hw/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [cpu_pkg::XLEN-1:0]       rs1_data,
    output logic [cpu_pkg::XLEN-1:0]       rs2_data,
    input  logic                           wr_en,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr,
    input  logic [cpu_pkg::XLEN-1:0]       wr_data
);
    import cpu_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // x0 is cleared by reset and never written, so it reads zero
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// File: hw/unified_memory.sv
`timescale 1ns/1ps

module unified_memory #(
    parameter int MEM_WORDS = 256
) (
    input  logic                             clk,
    input  cpu_pkg::imem_load_t              imem_load,
    input  logic                             instr_rd,
    input  logic [$clog2(MEM_WORDS)-1:0]     instr_addr,
    output logic [cpu_pkg::XLEN-1:0]         instr_data,
    input  logic                             data_rd,
    input  logic                             data_we,
    input  logic [$clog2(MEM_WORDS)-1:0]     data_addr,
    input  logic [cpu_pkg::XLEN-1:0]         data_wdata,
    output logic [cpu_pkg::XLEN-1:0]         data_rdata
);
    import cpu_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic [XLEN-1:0] mem [MEM_WORDS];

    // external load only happens while the core is idle
    always_ff @(posedge clk) begin
        if (imem_load.valid) begin
            mem[imem_load.addr[ADDR_W-1:0]] <= imem_load.data;
        end else if (data_we) begin
            mem[data_addr] <= data_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_rd) begin
            instr_data <= mem[instr_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (data_rd) begin
            data_rdata <= mem[data_addr];
        end
    end

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         start,
    input  logic                         next_pc_valid,
    input  logic [cpu_pkg::XLEN-1:0]     next_pc,
    output logic                         instr_rd,
    output logic [$clog2(MEM_WORDS)-1:0] instr_addr,
    output cpu_pkg::fetch_out_t          fetch_out
);
    import cpu_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic [XLEN-1:0] pc;
    logic            queued; // a pc token waits to be fetched

    assign instr_rd   = queued;
    assign instr_addr = pc[ADDR_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst) begin
            pc     <= '0;
            queued <= 1'b0;
        end else if (next_pc_valid) begin
            pc     <= next_pc; // token back from writeback
            queued <= 1'b1;
        end else if (start) begin
            queued <= 1'b1;
        end else if (instr_rd) begin
            queued <= 1'b0;
        end
    end

    // tag the returning instruction word with its pc
    always_ff @(posedge clk) begin
        if (!rst) begin
            fetch_out.valid <= 1'b0;
        end else begin
            fetch_out.valid <= instr_rd;
            fetch_out.pc    <= pc;
        end
    end

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  cpu_pkg::fetch_out_t            fetch_out,
    input  logic [cpu_pkg::XLEN-1:0]       instr_data,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [cpu_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [cpu_pkg::XLEN-1:0]       rs1_data,
    input  logic [cpu_pkg::XLEN-1:0]       rs2_data,
    output cpu_pkg::decode_out_t           decode_out
);
    import cpu_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    decode_out_t nxt;

    assign opcode   = opcode_e'(instr_data[6:0]);
    assign funct3   = instr_data[14:12];
    assign funct7   = instr_data[31:25];
    assign rs1_addr = instr_data[19:15];
    assign rs2_addr = instr_data[24:20];

    always_comb begin
        nxt         = '0;
        nxt.valid   = fetch_out.valid;
        nxt.pc      = fetch_out.pc;
        nxt.alu_op  = ADD;
        nxt.rs1_val = rs1_data;
        nxt.rs2_val = rs2_data;
        nxt.rd      = instr_data[11:7];
        case (opcode)
            OP: begin
                nxt.arith = 1'b1;
                nxt.we    = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: nxt.alu_op = ADD;
                    {7'b0100000, 3'b000}: nxt.alu_op = SUB;
                    {7'b0000000, 3'b100}: nxt.alu_op = XOR;
                    {7'b0000000, 3'b110}: nxt.alu_op = OR;
                    {7'b0000000, 3'b111}: nxt.alu_op = AND;
                    default:              nxt.illegal = 1'b1;
                endcase
            end
            OP_IMM: begin
                nxt.arith   = 1'b1;
                nxt.use_imm = 1'b1;
                nxt.we      = 1'b1;
                nxt.imm     = {{20{instr_data[31]}}, instr_data[31:20]};
                nxt.illegal = (funct3 != 3'b000); // addi only
            end
            LOAD: begin
                nxt.load    = 1'b1;
                nxt.use_imm = 1'b1;
                nxt.we      = 1'b1;
                nxt.imm     = {{20{instr_data[31]}}, instr_data[31:20]};
                nxt.illegal = (funct3 != 3'b010);
            end
            STORE: begin
                nxt.store   = 1'b1;
                nxt.use_imm = 1'b1;
                nxt.imm     = {{20{instr_data[31]}}, instr_data[31:25], instr_data[11:7]};
                nxt.illegal = (funct3 != 3'b010);
            end
            BRANCH: begin
                nxt.branch    = 1'b1;
                nxt.branch_ne = funct3[0];
                nxt.imm       = {{19{instr_data[31]}}, instr_data[31], instr_data[7],
                                 instr_data[30:25], instr_data[11:8], 1'b0};
                nxt.illegal   = (funct3[2:1] != 2'b00); // beq and bne only
            end
            JAL: begin
                nxt.jal = 1'b1;
                nxt.we  = 1'b1;
                nxt.imm = {{11{instr_data[31]}}, instr_data[31], instr_data[19:12],
                           instr_data[20], instr_data[30:21], 1'b0};
            end
            default: nxt.illegal = 1'b1;
        endcase
        if (nxt.illegal) begin
            nxt.arith  = 1'b0;
            nxt.load   = 1'b0;
            nxt.store  = 1'b0;
            nxt.branch = 1'b0;
            nxt.jal    = 1'b0;
            nxt.we     = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            decode_out.valid <= 1'b0;
        end else begin
            decode_out <= nxt;
        end
    end

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_pkg::decode_out_t  decode_out,
    output cpu_pkg::execute_out_t execute_out
);
    import cpu_pkg::*;

    logic [XLEN-1:0] operand_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] link;
    logic            equal;
    logic            taken;
    execute_out_t    nxt;

    assign operand_b = decode_out.use_imm ? decode_out.imm : decode_out.rs2_val;
    assign link      = decode_out.pc + 32'd4;
    assign equal     = (decode_out.rs1_val == decode_out.rs2_val);
    assign taken     = decode_out.branch && (decode_out.branch_ne ? !equal : equal);

    always_comb begin
        case (decode_out.alu_op)
            ADD:     alu_result = decode_out.rs1_val + operand_b;
            SUB:     alu_result = decode_out.rs1_val - operand_b;
            AND:     alu_result = decode_out.rs1_val & operand_b;
            OR:      alu_result = decode_out.rs1_val | operand_b;
            XOR:     alu_result = decode_out.rs1_val ^ operand_b;
            default: alu_result = decode_out.rs1_val + operand_b;
        endcase
    end

    always_comb begin
        nxt            = '0;
        nxt.valid      = decode_out.valid;
        nxt.pc         = decode_out.pc;
        nxt.load       = decode_out.load;
        nxt.store      = decode_out.store;
        nxt.illegal    = decode_out.illegal;
        nxt.result     = decode_out.jal ? link : alu_result; // loads and stores get the address
        nxt.store_data = decode_out.rs2_val;
        nxt.rd         = decode_out.rd;
        nxt.we         = decode_out.we;
        nxt.redirect   = decode_out.jal || taken;
        nxt.target     = decode_out.pc + decode_out.imm;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            execute_out.valid <= 1'b0;
        end else begin
            execute_out <= nxt;
        end
    end

endmodule

// File: hw/memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
    parameter int MEM_WORDS = 256
) (
    input  logic                         clk,
    input  logic                         rst,
    input  cpu_pkg::execute_out_t        execute_out,
    output logic                         data_rd,
    output logic                         data_we,
    output logic [$clog2(MEM_WORDS)-1:0] data_addr,
    output logic [cpu_pkg::XLEN-1:0]     data_wdata,
    input  logic [cpu_pkg::XLEN-1:0]     data_rdata,
    output cpu_pkg::mem_out_t            mem_out
);
    import cpu_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    mem_out_t stage_q;
    logic     load_q; // value comes from the data port

    assign data_rd    = execute_out.valid && execute_out.load;
    assign data_we    = execute_out.valid && execute_out.store;
    assign data_addr  = execute_out.result[ADDR_W+1:2];
    assign data_wdata = execute_out.store_data;

    always_ff @(posedge clk) begin
        if (!rst) begin
            stage_q.valid <= 1'b0;
            load_q        <= 1'b0;
        end else begin
            stage_q <= '{valid: execute_out.valid, pc: execute_out.pc,
                         illegal: execute_out.illegal, rd: execute_out.rd,
                         we: execute_out.we, redirect: execute_out.redirect,
                         target: execute_out.target, value: execute_out.result};
            load_q  <= data_rd;
        end
    end

    // load data lands together with the staged record
    always_comb begin
        mem_out = stage_q;
        if (load_q) begin
            mem_out.value = data_rdata;
        end
    end

endmodule

// File: hw/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
    input  logic                           clk,
    input  logic                           rst,
    input  cpu_pkg::mem_out_t              mem_out,
    output logic                           wr_en,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wr_addr,
    output logic [cpu_pkg::XLEN-1:0]       wr_data,
    output logic                           retire_valid,
    output cpu_pkg::retire_t               retire,
    output logic                           next_pc_valid,
    output logic [cpu_pkg::XLEN-1:0]       next_pc
);
    import cpu_pkg::*;

    logic commit_we;

    assign commit_we = mem_out.we && (mem_out.rd != '0); // x0 writes are dropped

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_en         <= 1'b0;
            retire_valid  <= 1'b0;
            next_pc_valid <= 1'b0;
        end else begin
            wr_en         <= mem_out.valid && commit_we;
            retire_valid  <= mem_out.valid;
            next_pc_valid <= mem_out.valid && !mem_out.illegal; // illegal halts the core
        end
    end

    always_ff @(posedge clk) begin
        wr_addr <= mem_out.rd;
        wr_data <= mem_out.value;
        retire  <= '{pc: mem_out.pc, rd: mem_out.rd, value: mem_out.value,
                     we: commit_we, illegal: mem_out.illegal};
        next_pc <= mem_out.redirect ? mem_out.target : mem_out.pc + 32'd4;
    end

endmodule

// File: hw/five_stage_core.sv
`timescale 1ns/1ps

module five_stage_core #(
    parameter int MEM_WORDS = 256
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  cpu_pkg::imem_load_t imem_load,
    output logic                retire_valid,
    output cpu_pkg::retire_t    retire
);
    import cpu_pkg::*;

    localparam int ADDR_W = $clog2(MEM_WORDS);

    logic                  next_pc_valid;
    logic [XLEN-1:0]       next_pc;
    logic                  instr_rd;
    logic [ADDR_W-1:0]     instr_addr;
    logic [XLEN-1:0]       instr_data;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  data_rd;
    logic                  data_we;
    logic [ADDR_W-1:0]     data_addr;
    logic [XLEN-1:0]       data_wdata;
    logic [XLEN-1:0]       data_rdata;
    logic                  wr_en;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [XLEN-1:0]       wr_data;
    fetch_out_t            fetch_out;
    decode_out_t           decode_out;
    execute_out_t          execute_out;
    mem_out_t              mem_out;

    fetch_stage #(.MEM_WORDS(MEM_WORDS)) u_fetch (
        .clk(clk), .rst(rst), .start(start),
        .next_pc_valid(next_pc_valid), .next_pc(next_pc),
        .instr_rd(instr_rd), .instr_addr(instr_addr), .fetch_out(fetch_out)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .fetch_out(fetch_out), .instr_data(instr_data),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .decode_out(decode_out)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .decode_out(decode_out), .execute_out(execute_out)
    );

    memory_stage #(.MEM_WORDS(MEM_WORDS)) u_memory (
        .clk(clk), .rst(rst), .execute_out(execute_out),
        .data_rd(data_rd), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_rdata(data_rdata), .mem_out(mem_out)
    );

    writeback_stage u_writeback (
        .clk(clk), .rst(rst), .mem_out(mem_out),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .retire_valid(retire_valid), .retire(retire),
        .next_pc_valid(next_pc_valid), .next_pc(next_pc)
    );

    register_file u_regs (
        .clk(clk), .rst(rst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    unified_memory #(.MEM_WORDS(MEM_WORDS)) u_mem (
        .clk(clk), .imem_load(imem_load),
        .instr_rd(instr_rd), .instr_addr(instr_addr), .instr_data(instr_data),
        .data_rd(data_rd), .data_we(data_we), .data_addr(data_addr),
        .data_wdata(data_wdata), .data_rdata(data_rdata)
    );

endmodule

// File: verif/core_chk.sv
`timescale 1ns/1ps

module core_chk (
    input logic clk,
    input logic rst,
    input logic start,
    input logic retire_valid
);

    a_retire_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        retire_valid |=> !retire_valid)
        else $error("retire strobe high in two consecutive cycles");

    a_retire_not_with_start: assert property (@(posedge clk) disable iff (!rst)
        !(retire_valid && start))
        else $error("retire strobe high together with start");

    // one reset edge clears the strobe, so check from the second one on
    a_retire_quiet_in_reset: assert property (@(posedge clk)
        !rst |=> (rst || !retire_valid))
        else $error("retire strobe high during reset");

endmodule

bind five_stage_core core_chk u_chk (
    .clk(clk), .rst(rst), .start(start), .retire_valid(retire_valid)
);

// File: verif/retire_scoreboard.sv
`timescale 1ns/1ps

module retire_scoreboard #(
    parameter int NUM_ROWS   = 24,
    parameter int NAME_W     = 96,
    parameter int RETIRE_GAP = 6
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           start,
    input  logic                           retire_valid,
    input  cpu_pkg::retire_t               retire,
    input  logic [NAME_W-1:0]              row_name    [NUM_ROWS],
    input  logic [cpu_pkg::XLEN-1:0]       row_addr    [NUM_ROWS],
    input  logic                           row_retire  [NUM_ROWS],
    input  logic [cpu_pkg::REG_ADDR_W-1:0] row_rd      [NUM_ROWS],
    input  logic [cpu_pkg::XLEN-1:0]       row_value   [NUM_ROWS],
    input  logic                           row_we      [NUM_ROWS],
    input  logic                           row_illegal [NUM_ROWS],
    output int                             error_count,
    output int                             retired_count,
    output int                             expected_left,
    output logic                           halt_seen
);
    import cpu_pkg::*;

    int next_row;  // next row that should retire
    int cycle;
    int last_mark; // cycle of the start strobe or the previous retirement

    function automatic int next_expected(input int from);
        int i;
        int found;
        found = NUM_ROWS;
        for (i = NUM_ROWS - 1; i >= from; i--) begin
            if (row_retire[i]) found = i;
        end
        return found;
    endfunction

    function automatic int count_expected();
        int i;
        int n;
        n = 0;
        for (i = 0; i < NUM_ROWS; i++) begin
            if (row_retire[i]) n++;
        end
        return n;
    endfunction

    // row that must never retire at this pc, or -1
    function automatic int skipped_row(input logic [XLEN-1:0] pc);
        int i;
        int found;
        found = -1;
        for (i = 0; i < NUM_ROWS; i++) begin
            if (!row_retire[i] && {row_addr[i][XLEN-3:0], 2'b00} == pc) found = i;
        end
        return found;
    endfunction

    task automatic compare(input int row, input string field, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
        if (exp !== act) begin
            error_count++;
            $display("FAILED %0s %0s: expected %h, actual %h", row_name[row], field, exp, act);
        end
    endtask

    task automatic check_retirement();
        int skip;
        int gap;
        skip = skipped_row(retire.pc);
        gap  = cycle - last_mark;
        if (halt_seen) begin
            error_count++;
            $display("ERROR: instruction at pc %h retired after the core halted", retire.pc);
        end else if (skip >= 0) begin
            error_count++;
            $display("ERROR: %0s at pc %h retired but should have been skipped",
                     row_name[skip], retire.pc);
        end else if (next_row >= NUM_ROWS) begin
            error_count++;
            $display("ERROR: unexpected retirement at pc %h", retire.pc);
        end else begin
            compare(next_row, "pc", {row_addr[next_row][XLEN-3:0], 2'b00}, retire.pc);
            compare(next_row, "illegal", XLEN'(row_illegal[next_row]), XLEN'(retire.illegal));
            compare(next_row, "we", XLEN'(row_we[next_row]), XLEN'(retire.we));
            if (row_we[next_row]) begin
                compare(next_row, "rd", XLEN'(row_rd[next_row]), XLEN'(retire.rd));
                compare(next_row, "value", row_value[next_row], retire.value);
            end
            expected_left--;
            next_row = next_expected(next_row + 1);
        end
        if (gap != RETIRE_GAP) begin
            error_count++;
            $display("ERROR: retirement at pc %h came %0d cycles after the previous one, not %0d",
                     retire.pc, gap, RETIRE_GAP);
        end
        if (retire.illegal) halt_seen = 1'b1;
        retired_count++;
        last_mark = cycle;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            error_count   = 0;
            retired_count = 0;
            halt_seen     = 1'b0;
            cycle         = 0;
            last_mark     = 0;
            next_row      = next_expected(0);
            expected_left = count_expected();
        end else begin
            cycle++;
            if (start) last_mark = cycle;
            if (retire_valid) check_retirement();
        end
    end

endmodule

// File: verif/core_tb.sv
`timescale 1ns/1ps

module core_tb;
    import cpu_pkg::*;

    localparam int MEM_WORDS    = 256;
    localparam int NUM_ROWS     = 24;
    localparam int NAME_W       = 8 * 12;
    localparam int HALT_TIMEOUT = 400; // cycles from start to the illegal retirement
    localparam int WATCH_CYCLES = 100;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic       clk;
    logic       rst;
    logic       start;
    imem_load_t imem_load;
    logic       retire_valid;
    retire_t    retire;

    logic [NAME_W-1:0]     row_name    [NUM_ROWS];
    logic [XLEN-1:0]       row_addr    [NUM_ROWS]; // word address
    logic [XLEN-1:0]       row_instr   [NUM_ROWS];
    logic                  row_retire  [NUM_ROWS];
    logic [REG_ADDR_W-1:0] row_rd      [NUM_ROWS];
    logic [XLEN-1:0]       row_value   [NUM_ROWS];
    logic                  row_we      [NUM_ROWS];
    logic                  row_illegal [NUM_ROWS];

    int   row_count;
    int   tb_errors;
    int   sb_errors;
    int   retired_count;
    int   expected_left;
    logic halt_seen;

    five_stage_core #(.MEM_WORDS(MEM_WORDS)) UUT (
        .clk(clk), .rst(rst), .start(start), .imem_load(imem_load),
        .retire_valid(retire_valid), .retire(retire)
    );

    retire_scoreboard #(.NUM_ROWS(NUM_ROWS), .NAME_W(NAME_W)) u_scoreboard (
        .clk(clk), .rst(rst), .start(start), .retire_valid(retire_valid), .retire(retire),
        .row_name(row_name), .row_addr(row_addr), .row_retire(row_retire),
        .row_rd(row_rd), .row_value(row_value), .row_we(row_we),
        .row_illegal(row_illegal), .error_count(sb_errors),
        .retired_count(retired_count), .expected_left(expected_left),
        .halt_seen(halt_seen)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd);
        return {funct7, rs2, rs1, funct3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    task automatic add_row(input logic [NAME_W-1:0] name, input logic [XLEN-1:0] instr,
                           input logic exp_retire, input logic [REG_ADDR_W-1:0] rd,
                           input logic [XLEN-1:0] value, input logic we, input logic illegal);
        if (row_count < NUM_ROWS) begin
            row_name[row_count]    = name;
            row_addr[row_count]    = XLEN'(row_count);
            row_instr[row_count]   = instr;
            row_retire[row_count]  = exp_retire;
            row_rd[row_count]      = rd;
            row_value[row_count]   = value;
            row_we[row_count]      = we;
            row_illegal[row_count] = illegal;
        end
        row_count++;
    endtask

    // x1 = 6 and x2 = -3 feed the alu rows and x9 holds the data base at byte 0x200
    task automatic build_table();
        row_count = 0;
        add_row("addi_pos", i_type(12'd6, 5'd0, 3'd0, 5'd1, OPC_OP_IMM),
                1'b1, 5'd1, 32'd6, 1'b1, 1'b0);
        add_row("addi_neg", i_type(12'hffd, 5'd0, 3'd0, 5'd2, OPC_OP_IMM),
                1'b1, 5'd2, 32'hffff_fffd, 1'b1, 1'b0);
        add_row("add", r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3),
                1'b1, 5'd3, 32'd3, 1'b1, 1'b0);
        add_row("sub", r_type(7'h20, 5'd2, 5'd1, 3'd0, 5'd4),
                1'b1, 5'd4, 32'd9, 1'b1, 1'b0);
        add_row("and", r_type(7'h00, 5'd2, 5'd1, 3'd7, 5'd5),
                1'b1, 5'd5, 32'd4, 1'b1, 1'b0);
        add_row("or", r_type(7'h00, 5'd2, 5'd1, 3'd6, 5'd6),
                1'b1, 5'd6, 32'hffff_ffff, 1'b1, 1'b0);
        add_row("xor", r_type(7'h00, 5'd2, 5'd1, 3'd4, 5'd7),
                1'b1, 5'd7, 32'hffff_fffb, 1'b1, 1'b0);
        add_row("addi_x0", i_type(12'd7, 5'd1, 3'd0, 5'd0, OPC_OP_IMM),
                1'b1, 5'd0, 32'd0, 1'b0, 1'b0);
        add_row("read_x0", r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd8),
                1'b1, 5'd8, 32'd6, 1'b1, 1'b0);
        add_row("addi_base", i_type(12'h200, 5'd0, 3'd0, 5'd9, OPC_OP_IMM),
                1'b1, 5'd9, 32'h0000_0200, 1'b1, 1'b0);
        add_row("sw", s_type(12'd0, 5'd4, 5'd9),
                1'b1, 5'd0, 32'd0, 1'b0, 1'b0);
        add_row("lw", i_type(12'd0, 5'd9, 3'd2, 5'd10, OPC_LOAD),
                1'b1, 5'd10, 32'd9, 1'b1, 1'b0);
        add_row("beq_taken", b_type(13'd8, 5'd8, 5'd1, 3'd0),
                1'b1, 5'd0, 32'd0, 1'b0, 1'b0);
        add_row("beq_skip", i_type(12'd1, 5'd0, 3'd0, 5'd11, OPC_OP_IMM),
                1'b0, 5'd11, 32'd1, 1'b1, 1'b0);
        add_row("bne_taken", b_type(13'd8, 5'd2, 5'd1, 3'd1),
                1'b1, 5'd0, 32'd0, 1'b0, 1'b0);
        add_row("bne_skip", i_type(12'd2, 5'd0, 3'd0, 5'd11, OPC_OP_IMM),
                1'b0, 5'd11, 32'd2, 1'b1, 1'b0);
        add_row("beq_fall", b_type(13'd8, 5'd2, 5'd1, 3'd0),
                1'b1, 5'd0, 32'd0, 1'b0, 1'b0);
        add_row("bne_fall", b_type(13'd8, 5'd8, 5'd1, 3'd1),
                1'b1, 5'd0, 32'd0, 1'b0, 1'b0);
        add_row("jal", j_type(21'd12, 5'd12),
                1'b1, 5'd12, 32'd76, 1'b1, 1'b0);
        add_row("jal_skip1", i_type(12'd3, 5'd0, 3'd0, 5'd13, OPC_OP_IMM),
                1'b0, 5'd13, 32'd3, 1'b1, 1'b0);
        add_row("jal_skip2", i_type(12'd4, 5'd0, 3'd0, 5'd13, OPC_OP_IMM),
                1'b0, 5'd13, 32'd4, 1'b1, 1'b0);
        add_row("link_use", r_type(7'h00, 5'd10, 5'd12, 3'd0, 5'd14),
                1'b1, 5'd14, 32'd85, 1'b1, 1'b0);
        add_row("illegal", 32'h0000_007f,
                1'b1, 5'd0, 32'd0, 1'b0, 1'b1);
        add_row("after_halt", i_type(12'd9, 5'd0, 3'd0, 5'd15, OPC_OP_IMM),
                1'b0, 5'd15, 32'd9, 1'b1, 1'b0);
        if (row_count != NUM_ROWS) begin
            tb_errors++;
            $display("ERROR: table holds %0d rows instead of %0d", row_count, NUM_ROWS);
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < NUM_ROWS; i++) begin
            @(negedge clk);
            imem_load.valid = 1'b1;
            imem_load.addr  = row_addr[i];
            imem_load.data  = row_instr[i];
        end
        @(negedge clk);
        imem_load = '0;
    endtask

    task automatic wait_for_halt();
        int waited;
        waited = 0;
        while (!halt_seen && waited < HALT_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!halt_seen) begin
            tb_errors++;
            $display("ERROR: the core did not halt within %0d cycles of start", HALT_TIMEOUT);
        end
    endtask

    initial begin
        int total;
        rst       = 1'b0;
        start     = 1'b0;
        imem_load = '0;
        tb_errors = 0;
        build_table();
        repeat (5) @(negedge clk);
        rst = 1'b1;
        load_program();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_for_halt();
        if (halt_seen) begin
            repeat (WATCH_CYCLES) @(negedge clk); // late retirements show up in the scoreboard
        end
        if (expected_left != 0) begin
            tb_errors++;
            $display("ERROR: %0d expected retirements never happened", expected_left);
        end
        total = tb_errors + sb_errors;
        $display("errors: %0d (scoreboard %0d, testbench %0d), retirements seen: %0d",
                 total, sb_errors, tb_errors, retired_count);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/cpu_pkg.sv
hw/register_file.sv
hw/unified_memory.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/writeback_stage.sv
hw/five_stage_core.sv
verif/core_chk.sv
verif/retire_scoreboard.sv
verif/core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator, verdict taken from sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module core_tb -o core_sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/core_sim > sim.log 2>&1 ; cat sim.log
grep -qx "Test passed" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
